// File: design/boot_defs.svh
// ========================================
// Boot controller constants. IPID_COUNT must be even
// because IP IDs are hashed in pairs.
// ========================================
`ifndef BOOT_DEFS_SVH
`define BOOT_DEFS_SVH

// IP ID collection
`define IPID_COUNT          4
`define IPID_WORDS          16      // 16-bit words per IP ID

// GPIO register link
`define GPIO_W              32
`define GPIO_PACKET_W       104
`define GPIO_ODATA          6'h00
`define GPIO_IDATA          6'h05
`define SYS_BUS_WAKEUP      32'h0000_0040
`define WAKE_ACK_BIT        7
`define IPID_VALID_BIT      13
`define IPID_TRIGGER_BIT    12
`define IPID_INDEX_LSB      8
`define IPID_INDEX_W        4
`define IPID_START_BITS     16'h7A7A    // Upper half of the word
`define IPID_STOP_BITS      16'hB9B9

// Packet field offsets
`define PKT_RW_BIT          0
`define PKT_TYPE_LSB        10
`define PKT_DATA_LSB        58

// Secure memory
`define MEM_ADDR_W          3
`define CHIP_ID_ADDR        0

`endif

// File: design/boot_id_pkg.sv
// ========================================
// Identity, digest and FSM types of the boot flow
// ========================================
`default_nettype none

`include "boot_defs.svh"

package boot_id_pkg;

    typedef logic [255:0] id256_t;      // PUF, IP ID, digest or chip ID
    typedef logic [511:0] sha_block_t;
    typedef logic [15:0]  ipid_word_t;
    typedef logic [$clog2(`IPID_COUNT)-1:0] ipid_idx_t;

    typedef enum logic [2:0] {
        C_IDLE, C_WAKE, C_WAKE_WAIT, C_TRIGGER, C_WAIT_START, C_CAPTURE, C_STOP, C_DONE
    } collect_state_t;

    typedef enum logic [2:0] {
        D_IDLE, D_LOAD_LO, D_LOAD_HI, D_PULSE, D_GAP, D_WAIT, D_DONE
    } digest_state_t;

    // One state per boot step
    typedef enum logic [2:0] {
        B_MCSE, B_COLLECT, B_CHAIN, B_CHIP, B_WRITE, B_READ, B_DONE
    } boot_state_t;

endpackage

`default_nettype wire

// File: design/gpio_bus_pkg.sv
// ========================================
// GPIO register link and secure memory bus types
// ========================================
`default_nettype none

`include "boot_defs.svh"

package gpio_bus_pkg;

    // Word read back from the GPIO block
    typedef logic [`GPIO_W-1:0] gpio_word_t;

    // ODATA or IDATA code
    typedef logic [5:0] gpio_type_t;

    // Full register access packet, mostly zero
    typedef logic [`GPIO_PACKET_W-1:0] gpio_packet_t;

    typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;

endpackage

`default_nettype wire

// File: design/boot_ifs.sv
// ========================================
// Internal request links. Start is held by the
// requester until done is seen.
// ========================================
`default_nettype none
`timescale 1ns/1ns

interface ipid_store_if import boot_id_pkg::*;;
    logic       start;
    logic       done;       // Sticky once set
    ipid_idx_t  rd_index;
    id256_t     rd_data;    // Combinational from rd_index

    modport collector (input start, input rd_index, output done, output rd_data);
    modport flow (output start, input done);
    modport reader (output rd_index, input rd_data);
endinterface

interface digest_req_if import boot_id_pkg::*;;
    logic       start;
    logic       chain_mode;     // High hashes the IP ID store
    id256_t     block_value;
    logic       done;
    id256_t     digest;

    modport requester (
        output start, output chain_mode, output block_value,
        input  done, input digest
    );
    modport server (
        input  start, input chain_mode, input block_value,
        output done, output digest
    );
endinterface

interface mem_req_if import boot_id_pkg::*, gpio_bus_pkg::*;;
    logic       start;
    logic       write;
    mem_addr_t  addr;
    id256_t     wdata;
    logic       done;
    id256_t     rdata;

    modport requester (
        output start, output write, output addr, output wdata,
        input  done, input rdata
    );
    modport server (
        input  start, input write, input addr, input wdata,
        output done, output rdata
    );
endinterface

`default_nettype wire

// File: design/ipid_collector.sv
// ========================================
// GPIO wake and IP ID extraction. The peer shows
// each word for one valid cycle only.
// ========================================
`default_nettype none
`timescale 1ns/1ns

`include "boot_defs.svh"

module ipid_collector import boot_id_pkg::*, gpio_bus_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  gpio_word_t      gpio_reg_rdata,
    output logic            gpio_reg_access,
    output gpio_packet_t    gpio_reg_packet,
    ipid_store_if.collector store
);

    localparam int WIDX_W = $clog2(`IPID_WORDS);

    collect_state_t state;
    ipid_idx_t      k_r;                // IP ID being fetched
    logic [WIDX_W:0] word_idx;
    logic           pkt_rw;             // 1 writes ODATA, 0 polls IDATA
    gpio_word_t     pkt_data;
    gpio_word_t     trig_word;
    ipid_word_t     upper;
    logic           valid, start_seen, stop_seen;
    ipid_word_t [`IPID_WORDS-1:0] word_buf;   // Word 0 at the LSB
    id256_t         ipid_mem [`IPID_COUNT];

    assign valid      = gpio_reg_rdata[`IPID_VALID_BIT];
    assign upper      = gpio_reg_rdata[`GPIO_W-1 -: 16];
    assign start_seen = valid && (upper == `IPID_START_BITS);
    assign stop_seen  = valid && (upper == `IPID_STOP_BITS);

    always_comb begin
        trig_word = '0;
        trig_word[`IPID_TRIGGER_BIT] = 1'b1;
        trig_word[`IPID_INDEX_LSB +: `IPID_INDEX_W] = `IPID_INDEX_W'(k_r);
    end

    always_comb begin
        gpio_reg_packet = '0;
        gpio_reg_packet[`PKT_RW_BIT] = pkt_rw;
        gpio_reg_packet[`PKT_TYPE_LSB +: 6] = pkt_rw ? `GPIO_ODATA : `GPIO_IDATA;
        gpio_reg_packet[`PKT_DATA_LSB +: `GPIO_W] = pkt_data;
    end

    assign store.done    = (state == C_DONE);
    assign store.rd_data = ipid_mem[store.rd_index];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state           <= C_IDLE;
            k_r             <= '0;
            word_idx        <= '0;
            pkt_rw          <= 1'b0;
            pkt_data        <= '0;
            gpio_reg_access <= 1'b0;
        end else begin
            gpio_reg_access <= 1'b1;
            pkt_rw          <= 1'b0;    // Poll unless a write is due
            pkt_data        <= '0;
            case (state)
                C_IDLE: if (store.start) state <= C_WAKE;
                C_WAKE: begin
                    pkt_rw   <= 1'b1;
                    pkt_data <= `SYS_BUS_WAKEUP;
                    state    <= C_WAKE_WAIT;
                end
                C_WAKE_WAIT: if (gpio_reg_rdata[`WAKE_ACK_BIT]) state <= C_TRIGGER;
                C_TRIGGER: begin
                    pkt_rw   <= 1'b1;
                    pkt_data <= trig_word;
                    state    <= C_WAIT_START;
                end
                C_WAIT_START: begin
                    word_idx <= '0;
                    if (start_seen) state <= C_CAPTURE;
                end
                C_CAPTURE: begin
                    if (stop_seen) begin    // Early stop, retry same k
                        pkt_rw <= 1'b1;
                        state  <= C_TRIGGER;
                    end else if (valid) begin
                        word_idx <= word_idx + 1'b1;
                        if (word_idx == (WIDX_W+1)'(`IPID_WORDS - 1)) state <= C_STOP;
                    end
                end
                C_STOP: begin
                    if (valid) begin
                        pkt_rw <= 1'b1;
                        state  <= C_TRIGGER;    // Missing stop discards
                        if (stop_seen) begin
                            k_r <= k_r + 1'b1;
                            if (k_r == ipid_idx_t'(`IPID_COUNT - 1)) state <= C_DONE;
                        end
                    end
                end
                default: state <= C_DONE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == C_CAPTURE && valid && !stop_seen)
            word_buf[word_idx[WIDX_W-1:0]] <= upper;
        if (state == C_STOP && stop_seen)
            ipid_mem[k_r] <= id256_t'(word_buf);
    end

    assert property (@(posedge clk) disable iff (!rst)
        (state == C_CAPTURE) |-> (word_idx < `IPID_WORDS));

endmodule

`default_nettype wire

// File: design/digest_sequencer.sv
// ========================================
// SHA engine driver. Chain mode hashes IP IDs
// in pairs with init first and next after.
// ========================================
`default_nettype none
`timescale 1ns/1ns

`include "boot_defs.svh"

module digest_sequencer import boot_id_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  id256_t          sha_digest,
    input  logic            sha_ready,
    input  logic            sha_digest_valid,
    output sha_block_t      sha_block,
    output logic            sha_init,
    output logic            sha_next,
    digest_req_if.server    req,
    ipid_store_if.reader    rd
);

    digest_state_t state;
    ipid_idx_t     k_r;
    logic          first_r, last_r;
    id256_t        lo_stage;    // IP ID k while k+1 is read
    id256_t        digest_r;

    assign rd.rd_index = k_r;
    assign req.done    = (state == D_DONE);
    assign req.digest  = digest_r;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state    <= D_IDLE;
            k_r      <= '0;
            first_r  <= 1'b0;
            last_r   <= 1'b0;
            sha_init <= 1'b0;
            sha_next <= 1'b0;
        end else begin
            sha_init <= 1'b0;
            sha_next <= 1'b0;
            case (state)
                D_IDLE: begin
                    k_r     <= '0;
                    first_r <= 1'b1;
                    last_r  <= 1'b1;    // Single block by default
                    if (req.start && req.chain_mode) begin
                        state <= D_LOAD_LO;
                    end else if (req.start) begin
                        sha_init <= 1'b1;
                        state    <= D_PULSE;
                    end
                end
                D_LOAD_LO: begin
                    k_r   <= k_r + 1'b1;
                    state <= D_LOAD_HI;
                end
                D_LOAD_HI: begin
                    sha_init <= first_r;
                    sha_next <= !first_r;
                    first_r  <= 1'b0;
                    last_r   <= (k_r == ipid_idx_t'(`IPID_COUNT - 1));
                    k_r      <= k_r + 1'b1;
                    state    <= D_PULSE;
                end
                D_PULSE: state <= D_GAP;
                D_GAP:   state <= D_WAIT;
                D_WAIT: begin
                    if (sha_ready && (req.chain_mode || sha_digest_valid))
                        state <= (req.chain_mode && !last_r) ? D_LOAD_LO : D_DONE;
                end
                default: state <= D_IDLE;   // Done lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == D_LOAD_LO)
            lo_stage <= rd.rd_data;
        if (state == D_LOAD_HI)
            sha_block <= {rd.rd_data, lo_stage};
        else if (state == D_IDLE && req.start && !req.chain_mode)
            sha_block <= {{$bits(id256_t){1'b0}}, req.block_value};
        if (state == D_WAIT)
            digest_r <= sha_digest;
    end

    assert property (@(posedge clk) disable iff (!rst) !(sha_init && sha_next));

endmodule

`default_nettype wire

// File: design/secure_mem_port.sv
// ========================================
// Secure memory sequencing. Writes last one cycle
// and reads hold until rdData_valid.
// ========================================
`default_nettype none
`timescale 1ns/1ns

module secure_mem_port import boot_id_pkg::*, gpio_bus_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  id256_t        rdData,
    input  logic          rdData_valid,
    output logic          rd_en,
    output logic          wr_en,
    output mem_addr_t     addr,
    output id256_t        wrData,
    mem_req_if.server     req
);

    logic   done_r;
    logic   idle;
    id256_t rdata_r;

    assign idle      = !rd_en && !wr_en && !done_r;
    assign req.done  = done_r;
    assign req.rdata = rdata_r;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rd_en  <= 1'b0;
            wr_en  <= 1'b0;
            addr   <= '0;
            wrData <= '0;
            done_r <= 1'b0;
        end else begin
            done_r <= 1'b0;
            if (idle && req.start) begin
                wr_en  <= req.write;
                rd_en  <= !req.write;
                addr   <= req.addr;
                wrData <= req.write ? req.wdata : '0;
            end else if (wr_en || (rd_en && rdData_valid)) begin
                wr_en  <= 1'b0;     // Bus back to zero
                rd_en  <= 1'b0;
                addr   <= '0;
                wrData <= '0;
                done_r <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en && rdData_valid)
            rdata_r <= rdData;
    end

    assert property (@(posedge clk) disable iff (!rst) !(rd_en && wr_en));

endmodule

`default_nettype wire

// File: design/boot_sequencer.sv
// ========================================
// Boot flow. Runs once per reset, then holds
// boot_done and the match result.
// ========================================
`default_nettype none
`timescale 1ns/1ns

`include "boot_defs.svh"

module boot_sequencer import boot_id_pkg::*, gpio_bus_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  id256_t          cam_puf_out,
    input  id256_t          sha_puf_out,
    output logic            boot_done,
    output logic            chip_id_authentic,
    ipid_store_if.flow      store,
    digest_req_if.requester digest,
    mem_req_if.requester    mem
);

    boot_state_t state;
    id256_t      mcse_id_r;
    id256_t      ipid_hash_r;
    id256_t      chip_id_r;

    assign store.start = (state == B_COLLECT);

    assign digest.start       = (state == B_CHAIN) || (state == B_CHIP);
    assign digest.chain_mode  = (state == B_CHAIN);
    assign digest.block_value = mcse_id_r ^ ipid_hash_r;   // Chip ID preimage

    assign mem.start = (state == B_WRITE) || (state == B_READ);
    assign mem.write = (state == B_WRITE);
    assign mem.addr  = mem_addr_t'(`CHIP_ID_ADDR);
    assign mem.wdata = chip_id_r;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state             <= B_MCSE;
            boot_done         <= 1'b0;
            chip_id_authentic <= 1'b0;
        end else begin
            case (state)
                B_MCSE:    state <= B_COLLECT;
                B_COLLECT: if (store.done) state <= B_CHAIN;
                B_CHAIN:   if (digest.done) state <= B_CHIP;
                B_CHIP:    if (digest.done) state <= B_WRITE;
                B_WRITE:   if (mem.done) state <= B_READ;
                B_READ: begin
                    if (mem.done) begin
                        chip_id_authentic <= (mem.rdata == chip_id_r);
                        boot_done         <= 1'b1;
                        state             <= B_DONE;
                    end
                end
                default: state <= B_DONE;
            endcase
        end
    end

    // Identity values are valid only once their step has passed
    always_ff @(posedge clk) begin
        if (state == B_MCSE)
            mcse_id_r <= cam_puf_out ^ sha_puf_out;
        if (state == B_CHAIN && digest.done)
            ipid_hash_r <= digest.digest;
        if (state == B_CHIP && digest.done)
            chip_id_r <= digest.digest;
    end

endmodule

`default_nettype wire

// File: design/secure_boot_top.sv
// ========================================
// Secure boot controller top. PUF inputs must be
// stable from reset release.
// ========================================
`default_nettype none
`timescale 1ns/1ns

module secure_boot_top import boot_id_pkg::*, gpio_bus_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  gpio_word_t   gpio_reg_rdata,
    input  id256_t       cam_puf_out,
    input  id256_t       sha_puf_out,
    input  id256_t       sha_digest,
    input  logic         sha_ready,
    input  logic         sha_digest_valid,
    input  id256_t       rdData,
    input  logic         rdData_valid,
    output logic         gpio_reg_access,
    output gpio_packet_t gpio_reg_packet,
    output sha_block_t   sha_block,
    output logic         sha_init,
    output logic         sha_next,
    output logic         rd_en,
    output logic         wr_en,
    output mem_addr_t    addr,
    output id256_t       wrData,
    output logic         boot_done,
    output logic         chip_id_authentic
);

    ipid_store_if store_if ();
    digest_req_if digest_if ();
    mem_req_if    mem_if ();

    ipid_collector collector_inst (
        .clk, .rst, .gpio_reg_rdata, .gpio_reg_access, .gpio_reg_packet,
        .store (store_if.collector)
    );

    digest_sequencer digest_inst (
        .clk, .rst, .sha_digest, .sha_ready, .sha_digest_valid,
        .sha_block, .sha_init, .sha_next,
        .req (digest_if.server),
        .rd  (store_if.reader)
    );

    secure_mem_port mem_inst (
        .clk, .rst, .rdData, .rdData_valid, .rd_en, .wr_en, .addr, .wrData,
        .req (mem_if.server)
    );

    boot_sequencer boot_inst (
        .clk, .rst, .cam_puf_out, .sha_puf_out, .boot_done, .chip_id_authentic,
        .store  (store_if.flow),
        .digest (digest_if.requester),
        .mem    (mem_if.requester)
    );

endmodule

`default_nettype wire

// File: verification/tb_boot_peers.sv
// ========================================
// GPIO peripheral, SHA engine and secure memory
// models. All outputs change on the falling edge.
// ========================================
`default_nettype none
`timescale 1ns/1ns

`include "boot_defs.svh"

module tb_boot_peers import boot_id_pkg::*, gpio_bus_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`IPID_COUNT*256-1:0] ipid_flat,
    input  logic                       early_stop,     // Cut IP ID 1 short once
    input  logic                       tamper,         // Flip bit 0 on reads
    input  logic                       gpio_reg_access,
    input  gpio_packet_t               gpio_reg_packet,
    output gpio_word_t                 gpio_reg_rdata,
    input  sha_block_t                 sha_block,
    input  logic                       sha_init,
    input  logic                       sha_next,
    output id256_t                     sha_digest,
    output logic                       sha_ready,
    output logic                       sha_digest_valid,
    input  logic                       rd_en,
    input  logic                       wr_en,
    input  mem_addr_t                  addr,
    input  id256_t                     wrData,
    output id256_t                     rdData,
    output logic                       rdData_valid
);

    typedef enum {G_IDLE, G_WAKE, G_SEND} peer_state_t;

    peer_state_t g_state;
    int          g_wait;
    int          pos;               // 0 start, 1..16 words, then stop
    int          cur_k;
    logic        ack;
    logic        early_done;
    logic        cut_here;
    logic        pkt_write;
    gpio_word_t  pkt_data;
    gpio_word_t  rdata_r = '0;

    id256_t      sha_digest_r = '0;
    id256_t      sha_pending;
    logic        sha_ready_r = 1'b1;
    logic        sha_valid_r = 1'b0;
    int          sha_wait;

    id256_t      mem [2**`MEM_ADDR_W];
    id256_t      rd_data_r = '0;
    logic        rd_valid_r = 1'b0;
    logic        rd_busy = 1'b0;
    int          rd_wait;

    assign gpio_reg_rdata   = rdata_r;
    assign sha_digest       = sha_digest_r;
    assign sha_ready        = sha_ready_r;
    assign sha_digest_valid = sha_valid_r;
    assign rdData           = rd_data_r;
    assign rdData_valid     = rd_valid_r;

    assign pkt_write = gpio_reg_access && gpio_reg_packet[`PKT_RW_BIT]
                       && (gpio_reg_packet[`PKT_TYPE_LSB +: 6] == `GPIO_ODATA);
    assign pkt_data  = gpio_reg_packet[`PKT_DATA_LSB +: `GPIO_W];
    assign cut_here  = early_stop && !early_done && (cur_k == 1) && (pos == 6);

    function automatic gpio_word_t valid_word(input ipid_word_t upper);
        gpio_word_t w;
        w = {upper, 16'h0000};
        w[`IPID_VALID_BIT] = 1'b1;
        return w;
    endfunction

    always @(negedge clk) begin
        if (!rst) begin
            g_state    <= G_IDLE;
            g_wait     <= 0;
            pos        <= 0;
            cur_k      <= 0;
            ack        <= 1'b0;
            early_done <= 1'b0;
            rdata_r    <= '0;
        end else begin
            case (g_state)
                G_IDLE: begin
                    rdata_r <= ack ? (32'h1 << `WAKE_ACK_BIT) : '0;
                    if (pkt_write && pkt_data == `SYS_BUS_WAKEUP) begin
                        g_wait  <= 1 + int'($urandom % 4);
                        g_state <= G_WAKE;
                    end else if (pkt_write && pkt_data[`IPID_TRIGGER_BIT]) begin
                        ack     <= 1'b0;
                        cur_k   <= int'(pkt_data[`IPID_INDEX_LSB +: `IPID_INDEX_W]);
                        pos     <= 0;
                        g_state <= G_SEND;
                    end
                end
                G_WAKE: begin
                    g_wait <= g_wait - 1;
                    if (g_wait == 1) begin
                        ack     <= 1'b1;
                        g_state <= G_IDLE;
                    end
                end
                default: begin
                    if ($urandom % 4 == 0) begin
                        rdata_r <= '0;      // Gap between words
                    end else if (pos == 0) begin
                        rdata_r <= valid_word(`IPID_START_BITS);
                        pos     <= 1;
                    end else if (pos <= `IPID_WORDS && !cut_here) begin
                        rdata_r <= valid_word(ipid_flat[cur_k*256 + (pos-1)*16 +: 16]);
                        pos     <= pos + 1;
                    end else begin
                        rdata_r    <= valid_word(`IPID_STOP_BITS);
                        early_done <= early_done || cut_here;
                        g_state    <= G_IDLE;
                    end
                end
            endcase
        end
    end

    // Init digest is hi ^ lo, next folds both halves into the previous one
    always @(negedge clk) begin
        if (!rst) begin
            sha_ready_r  <= 1'b1;
            sha_valid_r  <= 1'b0;
            sha_digest_r <= '0;
            sha_wait     <= 0;
        end else if (sha_init || sha_next) begin
            sha_ready_r <= 1'b0;
            sha_valid_r <= 1'b0;
            sha_wait    <= 1 + int'($urandom % 6);
            sha_pending <= (sha_init ? '0 : sha_digest_r) ^ sha_block[511:256] ^ sha_block[255:0];
        end else if (!sha_ready_r) begin
            sha_wait <= sha_wait - 1;
            if (sha_wait == 1) begin
                sha_ready_r  <= 1'b1;
                sha_valid_r  <= 1'b1;
                sha_digest_r <= sha_pending;
            end
        end
    end

    always @(negedge clk) begin
        rd_valid_r <= 1'b0;
        if (!rst) begin
            rd_busy <= 1'b0;
            rd_wait <= 0;
        end else begin
            if (wr_en)
                mem[addr] <= wrData;
            if (rd_en && !rd_busy && !rd_valid_r) begin
                rd_busy <= 1'b1;
                rd_wait <= 1 + int'($urandom % 4);
            end else if (rd_busy) begin
                rd_wait <= rd_wait - 1;
                if (rd_wait == 1) begin
                    rd_busy    <= 1'b0;
                    rd_valid_r <= 1'b1;
                    rd_data_r  <= mem[addr] ^ {{255{1'b0}}, tamper};
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verification/tb_secure_boot.sv
// ========================================
// Boot controller testbench. Run 2 cuts IP ID 1
// short once and tampers with the memory read.
// ========================================
`default_nettype none
`timescale 1ns/1ns

`include "boot_defs.svh"

module tb_secure_boot import boot_id_pkg::*, gpio_bus_pkg::*; ();

    localparam int BOOT_TIMEOUT = 4000;     // Cycles per boot

    logic         clk = 1'b0;
    logic         rst;
    id256_t       cam_puf_out;
    id256_t       sha_puf_out;
    gpio_word_t   gpio_reg_rdata;
    id256_t       sha_digest;
    logic         sha_ready;
    logic         sha_digest_valid;
    id256_t       rdData;
    logic         rdData_valid;
    logic         gpio_reg_access;
    gpio_packet_t gpio_reg_packet;
    sha_block_t   sha_block;
    logic         sha_init;
    logic         sha_next;
    logic         rd_en;
    logic         wr_en;
    mem_addr_t    addr;
    id256_t       wrData;
    logic         boot_done;
    logic         chip_id_authentic;

    logic [`IPID_COUNT*256-1:0] ipid_flat;
    logic         early_stop;
    logic         tamper;

    int           errors;
    int           tests;
    int           wr_count;
    id256_t       chip_exp;
    int           trig_exp [$];
    sha_block_t   blk_exp [$];
    logic         init_exp [$];

    always #2 clk = ~clk;

    secure_boot_top secure_boot_top_inst (
        .clk, .rst, .gpio_reg_rdata, .cam_puf_out, .sha_puf_out, .sha_digest,
        .sha_ready, .sha_digest_valid, .rdData, .rdData_valid, .gpio_reg_access,
        .gpio_reg_packet, .sha_block, .sha_init, .sha_next, .rd_en, .wr_en, .addr,
        .wrData, .boot_done, .chip_id_authentic
    );

    tb_boot_peers peers_inst (
        .clk, .rst, .ipid_flat, .early_stop, .tamper, .gpio_reg_access,
        .gpio_reg_packet, .gpio_reg_rdata, .sha_block, .sha_init, .sha_next,
        .sha_digest, .sha_ready, .sha_digest_valid, .rd_en, .wr_en, .addr,
        .wrData, .rdData, .rdData_valid
    );

    task automatic log_mismatch(input string name, input logic [511:0] got,
                                input logic [511:0] exp);
        errors++;
        $display("Mismatch %s: got 0x%0h, expected 0x%0h (at %0t)", name, got, exp, $time);
    endtask

    task automatic log_failure(input string what);
        errors++;
        $display("Failure at %0t: %s", $time, what);
    endtask

    function automatic id256_t draw_id256();
        id256_t v;
        for (int i = 0; i < 8; i++)
            v[32*i +: 32] = $urandom;
        return v;
    endfunction

    // Data words must never look like a marker
    function automatic ipid_word_t draw_ipid_word();
        ipid_word_t w;
        do begin
            w = 16'($urandom);
        end while (w == `IPID_START_BITS || w == `IPID_STOP_BITS);
        return w;
    endfunction

    task automatic check_gpio_packet();
        logic       rw;
        gpio_type_t ptype;
        gpio_word_t pdata;
        int         idx;
        int         idx_exp;
        rw    = gpio_reg_packet[`PKT_RW_BIT];
        ptype = gpio_reg_packet[`PKT_TYPE_LSB +: 6];
        pdata = gpio_reg_packet[`PKT_DATA_LSB +: `GPIO_W];
        assert (ptype == (rw ? `GPIO_ODATA : `GPIO_IDATA))
            else log_mismatch("gpio_reg_packet type", ptype, rw ? `GPIO_ODATA : `GPIO_IDATA);
        if (rw && pdata[`IPID_TRIGGER_BIT]) begin
            idx = int'(pdata[`IPID_INDEX_LSB +: `IPID_INDEX_W]);
            if (trig_exp.size() == 0) begin
                log_failure("trigger word written with no IP ID left to fetch");
            end else begin
                idx_exp = trig_exp.pop_front();
                assert (idx == idx_exp) else log_mismatch("trigger index", idx, idx_exp);
            end
        end
    endtask

    task automatic check_sha_pulse();
        sha_block_t blk;
        logic       is_init;
        assert (!(sha_init && sha_next)) else log_failure("sha_init and sha_next high together");
        if (sha_init || sha_next) begin
            if (blk_exp.size() == 0) begin
                log_failure("SHA pulse with no block left to hash");
            end else begin
                blk     = blk_exp.pop_front();
                is_init = init_exp.pop_front();
                assert (sha_init == is_init) else log_mismatch("sha_init", sha_init, is_init);
                assert (sha_block == blk) else log_mismatch("sha_block", sha_block, blk);
            end
        end
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            assert (!gpio_reg_access && !sha_init && !sha_next && !rd_en && !wr_en && !boot_done)
                else log_failure("an output was active during reset");
        end
    end

    always @(negedge clk) begin
        if (rst) begin
            if (gpio_reg_access)
                check_gpio_packet();
            check_sha_pulse();
            if (wr_en) begin
                wr_count++;
                assert (addr == mem_addr_t'(`CHIP_ID_ADDR))
                    else log_mismatch("addr", addr, `CHIP_ID_ADDR);
                assert (wrData == chip_exp) else log_mismatch("wrData", wrData, chip_exp);
            end
        end
    end

    task automatic run_boot(input int run_no, input logic inject, input logic auth_exp,
                            input string label);
        int     errors_before;
        int     cycles;
        int     k;
        int     w;
        id256_t mcse;
        id256_t chain;
        id256_t ipid_lo;
        id256_t ipid_hi;
        @(negedge clk);
        rst           = 1'b0;
        errors_before = errors;
        cam_puf_out   = draw_id256();
        sha_puf_out   = draw_id256();
        for (k = 0; k < `IPID_COUNT; k++)
            for (w = 0; w < `IPID_WORDS; w++)
                ipid_flat[k*256 + w*16 +: 16] = draw_ipid_word();
        early_stop = inject;
        tamper     = inject;
        wr_count   = 0;
        trig_exp.delete();
        blk_exp.delete();
        init_exp.delete();
        for (k = 0; k < `IPID_COUNT; k++) begin
            trig_exp.push_back(k);
            if (inject && k == 1)
                trig_exp.push_back(k);      // Retry after the early stop
        end
        mcse  = cam_puf_out ^ sha_puf_out;
        chain = '0;
        for (k = 0; k < `IPID_COUNT; k += 2) begin
            ipid_lo = ipid_flat[k*256 +: 256];
            ipid_hi = ipid_flat[(k+1)*256 +: 256];
            blk_exp.push_back({ipid_hi, ipid_lo});
            init_exp.push_back(k == 0);
            chain = (k == 0) ? (ipid_hi ^ ipid_lo) : (chain ^ ipid_hi ^ ipid_lo);
        end
        blk_exp.push_back({256'b0, mcse ^ chain});
        init_exp.push_back(1'b1);
        chip_exp = mcse ^ chain;    // Zero upper half leaves the lower half
        repeat (5) @(negedge clk);
        rst    = 1'b1;
        cycles = 0;
        while (!boot_done && cycles < BOOT_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!boot_done) begin
            log_failure("boot_done did not rise within the timeout");
        end else begin
            assert (chip_id_authentic == auth_exp)
                else log_mismatch("chip_id_authentic", chip_id_authentic, auth_exp);
        end
        assert (trig_exp.size() == 0) else log_failure("not every IP ID index was triggered");
        assert (blk_exp.size() == 0) else log_failure("not every SHA block was issued");
        assert (wr_count == 1) else log_mismatch("wr_en pulse count", wr_count, 1);
        tests++;
        $display("Run %0d (%s) finished after %0d cycles with %0d errors",
                 run_no, label, cycles, errors - errors_before);
    endtask

    initial begin
        void'($urandom(32'h53dd2ccf));
        rst         = 1'b0;
        cam_puf_out = '0;
        sha_puf_out = '0;
        ipid_flat   = '0;
        early_stop  = 1'b0;
        tamper      = 1'b0;
        errors      = 0;
        tests       = 0;
        wr_count    = 0;
        chip_exp    = '0;
        run_boot(1, 1'b0, 1'b1, "honest boot");
        run_boot(2, 1'b1, 1'b0, "early stop and tampered memory");
        $display("Tests run: %0d, errors: %0d", tests, errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+design
design/boot_id_pkg.sv
design/gpio_bus_pkg.sv
design/boot_ifs.sv
design/ipid_collector.sv
design/digest_sequencer.sv
design/secure_mem_port.sv
design/boot_sequencer.sv
design/secure_boot_top.sv
verification/tb_boot_peers.sv
verification/tb_secure_boot.sv

// File: run.sh
#!/bin/sh
# Builds the boot controller testbench with Verilator and runs it once.
# Exit status is 0 only when the simulation prints the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f --top-module tb_secure_boot \
    --Mdir obj_dir -o sim_secure_boot
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/sim_secure_boot)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -q "^TEST PASSED$"; then
    exit 0
fi
exit 1
